//--- include/pwr_consts.svh
`ifndef PWR_CONSTS_SVH
`define PWR_CONSTS_SVH

// ==========================================================================
// Sizes
// ==========================================================================
`define PWR_NUM_DOMAINS 3  // 0.6 V, 0.8 V, 1.0 V
`define PWR_CODE_W      8

// Thermal thresholds, degrees C
`define PWR_THERM_ALARM_C 85
`define PWR_THERM_WARN_C  75
`define PWR_THERM_EMERG_C 95

// Performance trend thresholds
`define PWR_TREND_STANDBY_LO 50
`define PWR_TREND_ADAPT_LO   25
`define PWR_TREND_WAKE       75
`define PWR_TREND_BOOST      90

`define PWR_XFER_CYCLES  4  // Cycles in the transition state
`define PWR_ADAPT_WINDOW 8  // Adaptive clamp around the active voltage

// ==========================================================================
// Per-state codes, packed as {1.0 V, 0.8 V, 0.6 V}
// ==========================================================================
`define PWR_RST_V {8'hA0, 8'h80, 8'h60}
`define PWR_RST_F {8'hFF, 8'h80, 8'h40}
`define PWR_ACT_V {8'hA0, 8'h80, 8'h60}
`define PWR_ACT_F {8'hFF, 8'hC0, 8'h80}
`define PWR_SBY_V {8'h98, 8'h78, 8'h58}
`define PWR_SBY_F {8'hC0, 8'h80, 8'h60}
`define PWR_LOW_V {8'h90, 8'h70, 8'h50}
`define PWR_LOW_F {8'h80, 8'h60, 8'h40}
`define PWR_THR_V {8'h88, 8'h68, 8'h48}  // Minimum safe voltages
`define PWR_THR_F {8'h70, 8'h50, 8'h30}

`endif

//--- design/pwr_pkg.sv
`default_nettype none

`include "pwr_consts.svh"

package pwr_pkg;

    // ======================================================================
    // Link and L0 micro-state encodings
    // ======================================================================

    typedef enum logic [1:0] {
        L0 = 2'd0,
        L1 = 2'd1,
        L2 = 2'd2,
        L3 = 2'd3
    } link_state_t;

    typedef enum logic [2:0] {
        ACTIVE    = 3'd0,
        STANDBY   = 3'd1,
        LOW_POWER = 3'd2,
        THROTTLED = 3'd3,
        ADAPTIVE  = 3'd4
    } micro_state_t;

    // One voltage or frequency code for a single domain
    typedef logic [`PWR_CODE_W-1:0] vf_code_t;

endpackage

`default_nettype wire

//--- design/sensor_frontend.sv
`timescale 1ns/1ns
`default_nettype none

`include "pwr_consts.svh"

module sensor_frontend (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [`PWR_NUM_DOMAINS-1:0] domain_en,
    input  logic [7:0]                  die_temperature,
    input  logic [15:0]                 performance_metrics,
    output logic [`PWR_NUM_DOMAINS-1:0] domain_ready,
    output logic                        therm_alarm,
    output logic                        therm_warn,
    output logic [15:0]                 perf_filtered,
    output logic [7:0]                  perf_trend
);

    logic [`PWR_NUM_DOMAINS-1:0] en_q;
    logic [17:0]                 filt_sum;

    // Domain enables, ready one cycle after the registered enable
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            en_q         <= '0;
            domain_ready <= '0;
        end else begin
            en_q         <= domain_en;
            domain_ready <= en_q & domain_en;  // Drop follows a disable directly
        end
    end

    // Thermal flags
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            therm_alarm <= 1'b0;
            therm_warn  <= 1'b0;
        end else begin
            therm_alarm <= (die_temperature > 8'(`PWR_THERM_ALARM_C));
            therm_warn  <= (die_temperature > 8'(`PWR_THERM_WARN_C));
        end
    end

    // IIR, 3/4 old plus 1/4 new
    assign filt_sum = 18'(perf_filtered) * 18'd3 + 18'(performance_metrics);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            perf_filtered <= '0;
            perf_trend    <= '0;
        end else begin
            perf_filtered <= filt_sum[17:2];
            perf_trend    <= perf_filtered[15:8];  // Upper byte is the trend
        end
    end

    // Warning threshold sits below the alarm threshold
    a_alarm_has_warn: assert property (@(posedge clk) disable iff (!rst_n)
        therm_alarm |-> therm_warn);

endmodule

`default_nettype wire

//--- design/power_state_fsm.sv
`timescale 1ns/1ns
`default_nettype none

`include "pwr_consts.svh"

module power_state_fsm (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [`PWR_NUM_DOMAINS-1:0] domain_en,
    input  logic [`PWR_NUM_DOMAINS-1:0] domain_ready,
    input  logic                        therm_alarm,
    input  logic [7:0]                  die_temperature,
    input  logic [7:0]                  perf_trend,
    input  logic                        over_budget,
    input  logic                        transition_req,
    input  pwr_pkg::link_state_t        transition_target,
    output logic                        transition_ack,
    output pwr_pkg::link_state_t        link_state,
    output pwr_pkg::micro_state_t       micro_state,
    output logic                        in_l0
);

    import pwr_pkg::*;

    localparam int CNT_W = $clog2(`PWR_XFER_CYCLES) + 1;

    typedef enum logic [3:0] {
        S_RESET, S_INIT,
        S_ACTIVE, S_STANDBY, S_LOW_POWER, S_THROTTLED, S_ADAPTIVE,
        S_XFER, S_L1, S_L2, S_L3
    } fsm_state_t;

    fsm_state_t       state, next_state;
    link_state_t      link_q;
    link_state_t      xfer_target;
    logic [CNT_W-1:0] xfer_cnt;
    logic             xfer_done;
    logic             req_away;  // Request to leave the current link state

    function automatic link_state_t link_of(fsm_state_t s, link_state_t hold);
        case (s)
            S_L1:    return L1;
            S_L2:    return L2;
            S_L3:    return L3;
            S_XFER:  return hold;
            default: return L0;
        endcase
    endfunction

    assign xfer_done = (xfer_cnt == CNT_W'(`PWR_XFER_CYCLES - 1));
    assign req_away  = transition_req && (transition_target != link_q);

    // ======================================================================
    // Next state
    // ======================================================================
    always_comb begin
        next_state = state;
        case (state)
            S_RESET: next_state = S_INIT;
            S_INIT: if (domain_ready == domain_en) next_state = S_ACTIVE;
            S_ACTIVE: begin
                if (req_away)         next_state = S_XFER;
                else if (therm_alarm) next_state = S_THROTTLED;
                else if (over_budget) next_state = S_LOW_POWER;
                else if (transition_req) begin
                    // L0 request picks a micro-state from the trend
                    if (perf_trend < 8'(`PWR_TREND_STANDBY_LO)) next_state = S_STANDBY;
                    else                                          next_state = S_ADAPTIVE;
                end
            end
            S_STANDBY: begin
                if (perf_trend > 8'(`PWR_TREND_WAKE)) next_state = S_ACTIVE;
                else if (therm_alarm)                 next_state = S_THROTTLED;
                else if (req_away)                    next_state = S_XFER;
            end
            S_LOW_POWER: begin
                if (!over_budget && !therm_alarm) next_state = S_STANDBY;
                else if (req_away)                next_state = S_XFER;
            end
            S_THROTTLED: begin
                if (!therm_alarm) next_state = S_STANDBY;
                else if (die_temperature > 8'(`PWR_THERM_EMERG_C)) next_state = S_L1;
            end
            S_ADAPTIVE: begin
                if (therm_alarm)                           next_state = S_THROTTLED;
                else if (over_budget)                      next_state = S_LOW_POWER;
                else if (perf_trend < 8'(`PWR_TREND_ADAPT_LO)) next_state = S_STANDBY;
                else if (req_away)                         next_state = S_XFER;
            end
            S_XFER: begin
                if (xfer_done) begin
                    case (xfer_target)
                        L1:      next_state = S_L1;
                        L2:      next_state = S_L2;
                        L3:      next_state = S_L3;
                        default: next_state = S_ACTIVE;
                    endcase
                end
            end
            S_L1, S_L2, S_L3: if (req_away) next_state = S_XFER;
            default: next_state = S_RESET;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= S_RESET;
            link_q   <= L0;
            xfer_cnt <= '0;
        end else begin
            state  <= next_state;
            link_q <= link_of(next_state, link_q);  // Target shows as XFER ends
            if (state == S_XFER && !xfer_done) xfer_cnt <= xfer_cnt + 1'b1;
            else                               xfer_cnt <= '0;
        end
    end

    // Target captured on acceptance
    always_ff @(posedge clk) begin
        if (next_state == S_XFER && state != S_XFER) xfer_target <= transition_target;
    end

    // ======================================================================
    // Outputs
    // ======================================================================
    always_comb begin
        in_l0 = 1'b1;
        case (state)
            S_STANDBY:   micro_state = STANDBY;
            S_LOW_POWER: micro_state = LOW_POWER;
            S_THROTTLED: micro_state = THROTTLED;
            S_ADAPTIVE:  micro_state = ADAPTIVE;
            S_ACTIVE:    micro_state = ACTIVE;
            default: begin
                micro_state = ACTIVE;
                in_l0       = 1'b0;
            end
        endcase
    end

    assign link_state     = link_q;
    assign transition_ack = !(state inside {S_RESET, S_INIT, S_XFER});

    a_ack_low_len: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(transition_ack) |->
            !transition_ack [*`PWR_XFER_CYCLES] ##1 (transition_ack && link_q == xfer_target));

    // Micro-states only run while the registered link state reads L0
    a_l0_link: assert property (@(posedge clk) disable iff (!rst_n)
        in_l0 |-> link_q == L0);

endmodule

`default_nettype wire

//--- design/avfs_controller.sv
`timescale 1ns/1ns
`default_nettype none

`include "pwr_consts.svh"

module avfs_controller (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  pwr_pkg::micro_state_t                       micro_state,
    input  logic                                        in_l0,
    input  logic                                        therm_warn,
    input  logic [7:0]                                  perf_trend,
    output pwr_pkg::vf_code_t [`PWR_NUM_DOMAINS-1:0]    voltage,
    output pwr_pkg::vf_code_t [`PWR_NUM_DOMAINS-1:0]    freq
);

    import pwr_pkg::*;

    localparam int N = `PWR_NUM_DOMAINS;
    localparam vf_code_t        WIN   = vf_code_t'(`PWR_ADAPT_WINDOW);
    localparam vf_code_t [N-1:0] ACT_V = `PWR_ACT_V;
    localparam vf_code_t [N-1:0] THR_V = `PWR_THR_V;

    vf_code_t [N-1:0] tgt_v;
    vf_code_t [N-1:0] tgt_f;

    // ======================================================================
    // Targets per micro-state, held outside L0
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tgt_v <= `PWR_RST_V;
            tgt_f <= `PWR_RST_F;
        end else if (in_l0) begin
            case (micro_state)
                STANDBY: begin
                    tgt_v <= `PWR_SBY_V;
                    tgt_f <= `PWR_SBY_F;
                end
                LOW_POWER: begin
                    tgt_v <= `PWR_LOW_V;
                    tgt_f <= `PWR_LOW_F;
                end
                THROTTLED: begin
                    tgt_v <= `PWR_THR_V;
                    tgt_f <= `PWR_THR_F;
                end
                ADAPTIVE: begin
                    tgt_f <= `PWR_ACT_F;
                    for (int d = 0; d < N; d++) begin
                        // Warning wins over boost, both clamped to the window
                        if (therm_warn) begin
                            if (tgt_v[d] > ACT_V[d] - WIN) tgt_v[d] <= tgt_v[d] - 1'b1;
                        end else if (perf_trend > 8'(`PWR_TREND_BOOST)) begin
                            if (tgt_v[d] < ACT_V[d] + WIN) tgt_v[d] <= tgt_v[d] + 1'b1;
                        end
                    end
                end
                default: begin
                    tgt_v <= `PWR_ACT_V;
                    tgt_f <= `PWR_ACT_F;
                end
            endcase
        end
    end

    // Slew limit, one step per cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            voltage <= `PWR_RST_V;
            freq    <= `PWR_RST_F;
        end else begin
            for (int d = 0; d < N; d++) begin
                if (voltage[d] < tgt_v[d])      voltage[d] <= voltage[d] + 1'b1;
                else if (voltage[d] > tgt_v[d]) voltage[d] <= voltage[d] - 1'b1;

                if (freq[d] < tgt_f[d])      freq[d] <= freq[d] + 1'b1;
                else if (freq[d] > tgt_f[d]) freq[d] <= freq[d] - 1'b1;
            end
        end
    end

    // Rail stays inside the table span widened by the adaptive window
    for (genvar d = 0; d < N; d++) begin : g_range
        a_volt_range: assert property (@(posedge clk) disable iff (!rst_n)
            (voltage[d] >= THR_V[d] - WIN) && (voltage[d] <= ACT_V[d] + WIN));
    end

endmodule

`default_nettype wire

//--- design/power_estimator.sv
`timescale 1ns/1ns
`default_nettype none

`include "pwr_consts.svh"

module power_estimator (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  pwr_pkg::vf_code_t [`PWR_NUM_DOMAINS-1:0]    voltage,
    input  pwr_pkg::vf_code_t [`PWR_NUM_DOMAINS-1:0]    freq,
    input  logic [15:0]                                 power_budget_mw,
    output logic [15:0]                                 power_mw,
    output logic                                        over_budget
);

    logic [15:0] prod;
    logic [15:0] est_sum;

    // V*F per domain, weighted by shifts of 6, 5 and 4
    always_comb begin
        est_sum = '0;
        prod    = '0;
        for (int d = 0; d < `PWR_NUM_DOMAINS; d++) begin
            prod    = 16'(voltage[d]) * 16'(freq[d]);
            est_sum = est_sum + (prod >> (6 - d));
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            power_mw    <= '0;
            over_budget <= 1'b0;
        end else begin
            power_mw    <= est_sum;
            over_budget <= (power_mw > power_budget_mw);  // One cycle behind
        end
    end

endmodule

`default_nettype wire

//--- design/power_manager_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "pwr_consts.svh"

module power_manager_top (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic [`PWR_NUM_DOMAINS-1:0]                 domain_en,
    input  logic [7:0]                                  die_temperature,
    input  logic [15:0]                                 performance_metrics,
    input  logic [15:0]                                 power_budget_mw,
    input  logic                                        transition_req,
    input  pwr_pkg::link_state_t                        transition_target,
    output logic                                        transition_ack,
    output logic [`PWR_NUM_DOMAINS-1:0]                 domain_status,
    output pwr_pkg::link_state_t                        link_state,
    output pwr_pkg::micro_state_t                       micro_power_state,
    output logic                                        thermal_throttle,
    output logic [15:0]                                 system_performance,
    output pwr_pkg::vf_code_t [`PWR_NUM_DOMAINS-1:0]    domain_voltage,
    output pwr_pkg::vf_code_t [`PWR_NUM_DOMAINS-1:0]    domain_freq,
    output logic [15:0]                                 power_consumption_mw,
    output logic                                        power_budget_alarm
);

    logic       therm_warn;
    logic [7:0] perf_trend;
    logic       in_l0;

    // ======================================================================
    // Input side
    // ======================================================================
    sensor_frontend u_sensor (
        .clk                 (clk),
        .rst_n               (rst_n),
        .domain_en           (domain_en),
        .die_temperature     (die_temperature),
        .performance_metrics (performance_metrics),
        .domain_ready        (domain_status),
        .therm_alarm         (thermal_throttle),
        .therm_warn          (therm_warn),
        .perf_filtered       (system_performance),
        .perf_trend          (perf_trend)
    );

    power_state_fsm u_fsm (
        .clk               (clk),
        .rst_n             (rst_n),
        .domain_en         (domain_en),
        .domain_ready      (domain_status),
        .therm_alarm       (thermal_throttle),
        .die_temperature   (die_temperature),
        .perf_trend        (perf_trend),
        .over_budget       (power_budget_alarm),  // Estimator feeds back
        .transition_req    (transition_req),
        .transition_target (transition_target),
        .transition_ack    (transition_ack),
        .link_state        (link_state),
        .micro_state       (micro_power_state),
        .in_l0             (in_l0)
    );

    // Output side
    avfs_controller u_avfs (
        .clk         (clk),
        .rst_n       (rst_n),
        .micro_state (micro_power_state),
        .in_l0       (in_l0),
        .therm_warn  (therm_warn),
        .perf_trend  (perf_trend),
        .voltage     (domain_voltage),
        .freq        (domain_freq)
    );

    power_estimator u_est (
        .clk             (clk),
        .rst_n           (rst_n),
        .voltage         (domain_voltage),
        .freq            (domain_freq),
        .power_budget_mw (power_budget_mw),
        .power_mw        (power_consumption_mw),
        .over_budget     (power_budget_alarm)
    );

endmodule

`default_nettype wire

//--- bench/tb_power_manager.sv
`timescale 1ns/1ns
`default_nettype none

`include "pwr_consts.svh"

module tb_power_manager;

    import pwr_pkg::*;

    // Row kinds for the request column
    localparam logic [1:0] RQ_NONE  = 2'd0;
    localparam logic [1:0] RQ_LEVEL = 2'd1;  // Held high for the whole row
    localparam logic [1:0] RQ_HS    = 2'd2;
    localparam logic [1:0] RQ_CHAIN = 2'd3;  // Second target set while ack is low

    // Code table rows
    localparam logic [2:0] C_RST = 3'd0;
    localparam logic [2:0] C_ACT = 3'd1;
    localparam logic [2:0] C_SBY = 3'd2;
    localparam logic [2:0] C_LOW = 3'd3;
    localparam logic [2:0] C_THR = 3'd4;
    localparam logic [2:0] C_ADP = 3'd5;

    typedef struct packed {
        logic [2:0]   en;
        logic [7:0]   temp;
        logic [15:0]  metric;
        logic [15:0]  budget;
        logic [1:0]   req;
        link_state_t  tgt;
        link_state_t  tgt2;
        logic [15:0]  hold;
        link_state_t  exp_link;
        micro_state_t exp_micro;
        logic         exp_thr;
        logic         exp_alarm;
        logic [2:0]   code;
    } row_t;

    logic                                     clk;
    logic                                     rst_n;
    logic [`PWR_NUM_DOMAINS-1:0]              domain_en;
    logic [7:0]                               die_temperature;
    logic [15:0]                              performance_metrics;
    logic [15:0]                              power_budget_mw;
    logic                                     transition_req;
    link_state_t                              transition_target;
    logic                                     transition_ack;
    logic [`PWR_NUM_DOMAINS-1:0]              domain_status;
    link_state_t                              link_state;
    micro_state_t                             micro_power_state;
    logic                                     thermal_throttle;
    logic [15:0]                              system_performance;
    vf_code_t [`PWR_NUM_DOMAINS-1:0]          domain_voltage;
    vf_code_t [`PWR_NUM_DOMAINS-1:0]          domain_freq;
    logic [15:0]                              power_consumption_mw;
    logic                                     power_budget_alarm;

    row_t        rows[$];
    row_t        r;
    logic [7:0]  v_tab [0:5][0:2];
    logic [7:0]  f_tab [0:5][0:2];
    integer      seed = 32'hb7b3_10fa;
    logic [15:0] cur_metric;
    int          errors = 0;
    int          cycles = 0;
    int          limit  = 32'h7fff_ffff;

    power_manager_top u_dut (
        .clk                  (clk),
        .rst_n                (rst_n),
        .domain_en            (domain_en),
        .die_temperature      (die_temperature),
        .performance_metrics  (performance_metrics),
        .power_budget_mw      (power_budget_mw),
        .transition_req       (transition_req),
        .transition_target    (transition_target),
        .transition_ack       (transition_ack),
        .domain_status        (domain_status),
        .link_state           (link_state),
        .micro_power_state    (micro_power_state),
        .thermal_throttle     (thermal_throttle),
        .system_performance   (system_performance),
        .domain_voltage       (domain_voltage),
        .domain_freq          (domain_freq),
        .power_consumption_mw (power_consumption_mw),
        .power_budget_alarm   (power_budget_alarm)
    );

    always #2 clk = ~clk;

    // Cycle limit guard
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("Timeout: run passed its limit of %0d cycles", limit);
            $display("Errors found");
            $finish;
        end
    end

    // ======================================================================
    // Helpers
    // ======================================================================
    task automatic report(input string msg);
        errors++;
        $display("Error @ %0t: %s", $time, msg);
    endtask

    // Noise on the low byte only, below the trend resolution
    task automatic drive_metric();
        performance_metrics = {cur_metric[15:8], 8'($random(seed))};
    endtask

    function automatic int power_rule(input vf_code_t [2:0] v, input vf_code_t [2:0] f);
        int sum;
        sum = 0;
        for (int d = 0; d < 3; d++) sum += (int'(v[d]) * int'(f[d])) >> (6 - d);
        return sum;
    endfunction

    task automatic run_handshake(input link_state_t first, input link_state_t last,
                                 input bit chained);
        int   falls;
        int   n;
        logic prev;
        bit   switched;
        falls    = 0;
        prev     = transition_ack;
        switched = !chained;
        transition_target = first;
        transition_req    = 1'b1;
        for (n = 0; n < 64; n++) begin
            @(negedge clk);
            drive_metric();
            if (prev && !transition_ack) falls++;
            prev = transition_ack;
            if (!transition_ack && !switched) begin
                transition_target = last;  // New request while busy
                switched = 1'b1;
            end
            if (transition_ack && link_state == last && falls >= (chained ? 2 : 1)) break;
        end
        transition_req = 1'b0;
        if (n == 64)
            $display("Handshake to link state %0d did not complete in 64 cycles", last);
        if (n == 64) errors++;
    endtask

    // Outputs held by reset
    task automatic check_reset();
        if (transition_ack !== 1'b0)
            report($sformatf("reset transition_ack %b, expected 0", transition_ack));
        if (domain_status !== '0)
            report($sformatf("reset domain_status %b, expected 0", domain_status));
        if (link_state !== L0)
            report($sformatf("reset link_state %0d, expected %0d", link_state, L0));
        if (micro_power_state !== ACTIVE)
            report($sformatf("reset micro state %0d, expected %0d",
                             micro_power_state, ACTIVE));
        if (thermal_throttle !== 1'b0)
            report($sformatf("reset thermal_throttle %b", thermal_throttle));
        if (power_budget_alarm !== 1'b0)
            report($sformatf("reset power_budget_alarm %b", power_budget_alarm));
        for (int d = 0; d < 3; d++) begin
            if (domain_voltage[d] !== v_tab[C_RST][d])
                report($sformatf("reset voltage[%0d] %h, expected %h", d,
                                 domain_voltage[d], v_tab[C_RST][d]));
            if (domain_freq[d] !== f_tab[C_RST][d])
                report($sformatf("reset freq[%0d] %h, expected %h", d,
                                 domain_freq[d], f_tab[C_RST][d]));
        end
    endtask

    task automatic check_row(input int i, input row_t x);
        int p;
        if (domain_status !== x.en)
            report($sformatf("row %0d domain_status %b, expected %b", i, domain_status, x.en));
        if (link_state !== x.exp_link)
            report($sformatf("row %0d link_state %0d, expected %0d", i, link_state, x.exp_link));
        if (micro_power_state !== x.exp_micro)
            report($sformatf("row %0d micro state %0d, expected %0d", i,
                             micro_power_state, x.exp_micro));
        if (thermal_throttle !== x.exp_thr)
            report($sformatf("row %0d thermal_throttle %b", i, thermal_throttle));
        if (power_budget_alarm !== x.exp_alarm)
            report($sformatf("row %0d power_budget_alarm %b", i, power_budget_alarm));
        // Filter has settled onto the metric's upper byte
        if (system_performance[15:8] !== x.metric[15:8])
            report($sformatf("row %0d system_performance %h, expected upper byte %h", i,
                             system_performance, x.metric[15:8]));
        for (int d = 0; d < 3; d++) begin
            if (domain_voltage[d] !== v_tab[x.code][d])
                report($sformatf("row %0d voltage[%0d] %h, expected %h", i, d,
                                 domain_voltage[d], v_tab[x.code][d]));
            if (domain_freq[d] !== f_tab[x.code][d])
                report($sformatf("row %0d freq[%0d] %h, expected %h", i, d,
                                 domain_freq[d], f_tab[x.code][d]));
        end
        p = power_rule(domain_voltage, domain_freq);
        if (power_consumption_mw !== 16'(p))
            report($sformatf("row %0d power %0d, expected %0d", i, power_consumption_mw, p));
    endtask

    // ======================================================================
    // Main sequence
    // ======================================================================
    initial begin
        clk                 = 1'b0;
        rst_n               = 1'b0;
        domain_en           = '0;
        die_temperature     = 8'd40;
        cur_metric          = 16'h6000;
        performance_metrics = 16'h6000;
        power_budget_mw     = 16'hFFFF;
        transition_req      = 1'b0;
        transition_target   = L0;

        // Index 0.6 V, 0.8 V, 1.0 V
        v_tab = '{'{8'h60, 8'h80, 8'hA0}, '{8'h60, 8'h80, 8'hA0}, '{8'h58, 8'h78, 8'h98},
                  '{8'h50, 8'h70, 8'h90}, '{8'h48, 8'h68, 8'h88}, '{8'h00, 8'h00, 8'h00}};
        f_tab = '{'{8'h40, 8'h80, 8'hFF}, '{8'h80, 8'hC0, 8'hFF}, '{8'h60, 8'h80, 8'hC0},
                  '{8'h40, 8'h60, 8'h80}, '{8'h30, 8'h50, 8'h70}, '{8'h00, 8'h00, 8'h00}};
        for (int d = 0; d < 3; d++) begin
            v_tab[5][d] = v_tab[1][d] + 8'(`PWR_ADAPT_WINDOW);  // Boosted to the clamp
            f_tab[5][d] = f_tab[1][d];
        end

        // en, temp, metric, budget, req, tgt, tgt2, hold, link, micro, thr, alarm, codes
        rows.push_back('{3'b111, 8'd40,  16'h6000, 16'hFFFF, RQ_NONE,  L0, L0, 16'd100,
                         L0, ACTIVE,    1'b0, 1'b0, C_ACT});
        rows.push_back('{3'b111, 8'd40,  16'h2000, 16'hFFFF, RQ_NONE,  L0, L0, 16'd60,
                         L0, ACTIVE,    1'b0, 1'b0, C_ACT});
        rows.push_back('{3'b111, 8'd40,  16'h2000, 16'hFFFF, RQ_LEVEL, L0, L0, 16'd100,
                         L0, STANDBY,   1'b0, 1'b0, C_SBY});
        rows.push_back('{3'b111, 8'd40,  16'h6000, 16'hFFFF, RQ_NONE,  L0, L0, 16'd100,
                         L0, ACTIVE,    1'b0, 1'b0, C_ACT});
        rows.push_back('{3'b111, 8'd40,  16'h3C00, 16'hFFFF, RQ_NONE,  L0, L0, 16'd60,
                         L0, ACTIVE,    1'b0, 1'b0, C_ACT});
        rows.push_back('{3'b111, 8'd40,  16'h3C00, 16'hFFFF, RQ_LEVEL, L0, L0, 16'd10,
                         L0, ADAPTIVE,  1'b0, 1'b0, C_ACT});
        rows.push_back('{3'b111, 8'd40,  16'h6000, 16'hFFFF, RQ_NONE,  L0, L0, 16'd60,
                         L0, ADAPTIVE,  1'b0, 1'b0, C_ADP});
        rows.push_back('{3'b111, 8'd90,  16'h6000, 16'hFFFF, RQ_NONE,  L0, L0, 16'd180,
                         L0, THROTTLED, 1'b1, 1'b0, C_THR});
        rows.push_back('{3'b111, 8'd100, 16'h6000, 16'hFFFF, RQ_NONE,  L0, L0, 16'd10,
                         L1, ACTIVE,    1'b1, 1'b0, C_THR});
        rows.push_back('{3'b111, 8'd40,  16'h6000, 16'hFFFF, RQ_NONE,  L0, L0, 16'd10,
                         L1, ACTIVE,    1'b0, 1'b0, C_THR});
        rows.push_back('{3'b111, 8'd40,  16'h6000, 16'hFFFF, RQ_HS,    L0, L0, 16'd180,
                         L0, ACTIVE,    1'b0, 1'b0, C_ACT});
        rows.push_back('{3'b111, 8'd40,  16'h2000, 16'd1000, RQ_NONE,  L0, L0, 16'd180,
                         L0, LOW_POWER, 1'b0, 1'b1, C_LOW});
        rows.push_back('{3'b111, 8'd40,  16'h2000, 16'hFFFF, RQ_NONE,  L0, L0, 16'd100,
                         L0, STANDBY,   1'b0, 1'b0, C_SBY});
        rows.push_back('{3'b111, 8'd40,  16'h2000, 16'hFFFF, RQ_HS,    L2, L2, 16'd10,
                         L2, ACTIVE,    1'b0, 1'b0, C_SBY});
        rows.push_back('{3'b111, 8'd40,  16'h2000, 16'hFFFF, RQ_CHAIN, L1, L3, 16'd10,
                         L3, ACTIVE,    1'b0, 1'b0, C_SBY});
        rows.push_back('{3'b111, 8'd40,  16'h2000, 16'hFFFF, RQ_HS,    L0, L0, 16'd100,
                         L0, ACTIVE,    1'b0, 1'b0, C_ACT});

        limit = 200;  // Reset plus margin
        foreach (rows[i]) limit += int'(rows[i].hold) + 64;

        repeat (3) @(posedge clk);
        @(negedge clk);
        check_reset();
        rst_n = 1'b1;

        for (int i = 0; i < rows.size(); i++) begin
            r = rows[i];
            @(negedge clk);
            domain_en       = r.en;
            die_temperature = r.temp;
            power_budget_mw = r.budget;
            cur_metric      = r.metric;
            drive_metric();
            transition_req    = (r.req == RQ_LEVEL);
            transition_target = r.tgt;
            if (r.req == RQ_HS || r.req == RQ_CHAIN)
                run_handshake(r.tgt, r.tgt2, r.req == RQ_CHAIN);
            repeat (int'(r.hold)) begin
                @(negedge clk);
                drive_metric();
            end
            check_row(i, r);
        end

        $display("Total errors: %0d", errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+include
design/pwr_pkg.sv
design/sensor_frontend.sv
design/power_state_fsm.sv
design/avfs_controller.sv
design/power_estimator.sv
design/power_manager_top.sv
bench/tb_power_manager.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f \
    --top-module tb_power_manager \
    --Mdir obj_dir -o tb_sim > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1

grep -qx "No errors" sim.log \
    && echo "PASS" \
    || { echo "FAIL, see sim.log"; exit 1; }
